/* dual_issue_settings.svh */
`ifndef DUAL_ISSUE_SETTINGS_SVH
`define DUAL_ISSUE_SETTINGS_SVH

// datapath
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// csr space
`define CSR_ADDR_W  12
`define CSR_FFLAGS  12'h001
`define CSR_FRM     12'h002
`define CSR_FCSR    12'h003
`define CSR_FSTATE  12'h7c0   // local, holds fs only

`endif

/* dual_issue_pkg.sv */
`include "dual_issue_settings.svh"

package dual_issue_pkg;

    // ##################################################
    // instruction slots
    // ##################################################

    typedef struct packed {
        logic rden1;
        logic rden2;
        logic wren;
        logic load;
        logic csr_read;
        logic csr_write;
        logic fp_op;
        logic fp_flags;   // op will update fflags
    } op_flags_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        op_flags_t              op;
        logic [`REG_ADDR_W-1:0] raddr1;
        logic [`REG_ADDR_W-1:0] raddr2;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`CSR_ADDR_W-1:0] caddr;
        logic [2:0]             rm;
    } slot_t;

    typedef struct packed {
        slot_t slot0;
        slot_t slot1;
    } slot_pair_t;

    // ##################################################
    // later stages
    // ##################################################

    typedef struct packed {
        logic                   valid;
        op_flags_t              op;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       result;   // not yet valid for a load in execute
    } stage_fb_t;

    typedef struct packed {
        stage_fb_t fb0;
        stage_fb_t fb1;
    } stage_pair_fb_t;

    typedef struct packed {
        logic                   wren;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
    } wb_port_t;

    // ##################################################
    // operands, csr and issued words
    // ##################################################

    typedef struct packed {
        logic                   rden1;
        logic                   rden2;
        logic [`REG_ADDR_W-1:0] raddr1;
        logic [`REG_ADDR_W-1:0] raddr2;
    } read_req_t;

    typedef struct packed {
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
    } read_data_t;

    typedef struct packed {
        logic                   strobe;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } csr_write_t;

    typedef struct packed {
        logic [1:0] fs;
        logic [2:0] frm;
        logic [4:0] fflags;
    } fp_status_t;

    typedef struct packed {
        slot_t            slot;
        logic [`XLEN-1:0] rdata1;
        logic [`XLEN-1:0] rdata2;
        logic [`XLEN-1:0] crdata;
    } issued_t;

    typedef struct packed {
        issued_t issued0;
        issued_t issued1;
    } issued_pair_t;

endpackage

/* register_file.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module register_file (
    input  logic                       clock,
    input  logic                       reset,
    input  dual_issue_pkg::read_req_t  rd0,
    input  dual_issue_pkg::read_req_t  rd1,
    input  dual_issue_pkg::wb_port_t   wb0,
    input  dual_issue_pkg::wb_port_t   wb1,
    output dual_issue_pkg::read_data_t data0,
    output dual_issue_pkg::read_data_t data1
);

    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];   // x0 is not stored

    function automatic logic [`XLEN-1:0] read_port(
        input logic                   en,
        input logic [`REG_ADDR_W-1:0] addr
    );
        logic [`XLEN-1:0] value;
        value = '0;
        if (en && addr != '0) begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            if (wb0.wren && wb0.waddr != '0) regs[wb0.waddr] <= wb0.wdata;
            if (wb1.wren && wb1.waddr != '0) regs[wb1.waddr] <= wb1.wdata;  // wb1 wins
        end
    end

    // no write-through, forwarding covers same-cycle writes
    assign data0.rdata1 = read_port(rd0.rden1, rd0.raddr1);
    assign data0.rdata2 = read_port(rd0.rden2, rd0.raddr2);
    assign data1.rdata1 = read_port(rd1.rden1, rd1.raddr1);
    assign data1.rdata2 = read_port(rd1.rden2, rd1.raddr2);

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module operand_forward (
    input  dual_issue_pkg::read_req_t      req,
    input  dual_issue_pkg::read_data_t     reg_data,
    input  dual_issue_pkg::stage_pair_fb_t exec_fb,
    input  dual_issue_pkg::stage_pair_fb_t mem_fb,
    input  dual_issue_pkg::wb_port_t       wb0,
    input  dual_issue_pkg::wb_port_t       wb1,
    output dual_issue_pkg::read_data_t     data
);
    import dual_issue_pkg::*;

    function automatic logic stage_hit(
        input stage_fb_t              s,
        input logic [`REG_ADDR_W-1:0] addr
    );
        return s.valid && s.op.wren && (s.waddr == addr);
    endfunction

    function automatic logic [`XLEN-1:0] pick(
        input logic                   en,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       reg_value
    );
        logic [`XLEN-1:0] value;
        value = reg_value;
        if (en && addr != '0) begin
            // oldest source first, each younger hit overrides
            if (wb0.wren && wb0.waddr == addr) value = wb0.wdata;
            if (wb1.wren && wb1.waddr == addr) value = wb1.wdata;
            if (stage_hit(mem_fb.fb0, addr)) value = mem_fb.fb0.result;
            if (stage_hit(mem_fb.fb1, addr)) value = mem_fb.fb1.result;
            if (stage_hit(exec_fb.fb0, addr) && !exec_fb.fb0.op.load) value = exec_fb.fb0.result;
            if (stage_hit(exec_fb.fb1, addr) && !exec_fb.fb1.op.load) value = exec_fb.fb1.result;
        end
        return value;
    endfunction

    assign data.rdata1 = pick(req.rden1, req.raddr1, reg_data.rdata1);
    assign data.rdata2 = pick(req.rden2, req.raddr2, reg_data.rdata2);

endmodule

/* fp_status_regs.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module fp_status_regs (
    input  logic                       clock,
    input  logic                       reset,
    input  dual_issue_pkg::csr_write_t csr_wr,
    input  logic [`CSR_ADDR_W-1:0]     read_addr,
    output dual_issue_pkg::fp_status_t status,
    output logic [`XLEN-1:0]           read_data
);

    logic [1:0] fs;       // 0 means fp unit off
    logic [2:0] frm;
    logic [4:0] fflags;

    always_ff @(posedge clock) begin
        if (!reset) begin
            fs     <= 2'b00;
            frm    <= 3'b000;
            fflags <= 5'b00000;
        end else if (csr_wr.strobe) begin
            case (csr_wr.addr)
                `CSR_FFLAGS: fflags <= csr_wr.data[4:0];
                `CSR_FRM:    frm    <= csr_wr.data[2:0];
                `CSR_FCSR: begin
                    frm    <= csr_wr.data[7:5];
                    fflags <= csr_wr.data[4:0];
                end
                `CSR_FSTATE: fs <= csr_wr.data[1:0];
                default: ;
            endcase
        end
    end

    assign status.fs     = fs;
    assign status.frm    = frm;
    assign status.fflags = fflags;

    always_comb begin
        read_data = '0;   // foreign addresses read zero
        case (read_addr)
            `CSR_FFLAGS: read_data[4:0] = fflags;
            `CSR_FRM:    read_data[2:0] = frm;
            `CSR_FCSR:   read_data[7:0] = {frm, fflags};
            `CSR_FSTATE: read_data[1:0] = fs;
            default: ;
        endcase
    end

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module issue_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  dual_issue_pkg::slot_pair_t     pair,
    input  dual_issue_pkg::stage_pair_fb_t exec_fb,
    input  dual_issue_pkg::stage_pair_fb_t mem_fb,
    input  logic                           flush,
    input  dual_issue_pkg::fp_status_t     status,
    output dual_issue_pkg::read_req_t      rd0,
    output dual_issue_pkg::read_req_t      rd1,
    input  dual_issue_pkg::read_data_t     fwd0,
    input  dual_issue_pkg::read_data_t     fwd1,
    output logic [`CSR_ADDR_W-1:0]         csr_addr,
    input  logic [`XLEN-1:0]               csr_data,
    output logic                           stall,
    output dual_issue_pkg::issued_pair_t   issued
);
    import dual_issue_pkg::*;

    slot_t        slot0;
    slot_t        slot1;
    stage_fb_t    later [4];   // exec and mem slots
    logic         csr_in_flight;
    logic         fp_in_flight;
    logic         load_use;
    issued_pair_t issued_next;

    // ##################################################
    // fp gating and hazard helpers
    // ##################################################

    function automatic slot_t gate_fp(input slot_t s, input fp_status_t st);
        slot_t g;
        g = s;
        if (st.fs == 2'b00) begin
            g.op.fp_op    = 1'b0;
            g.op.fp_flags = 1'b0;
            g.rm          = 3'b000;
        end
        if (g.rm == 3'b111) begin
            g.rm = st.frm;   // dynamic rounding mode
        end
        return g;
    endfunction

    function automatic logic load_use_hit(input stage_fb_t e, input slot_t s);
        logic hit1;
        logic hit2;
        hit1 = s.op.rden1 && (s.raddr1 == e.waddr);
        hit2 = s.op.rden2 && (s.raddr2 == e.waddr);
        return s.valid && e.valid && e.op.load && (e.waddr != '0) && (hit1 || hit2);
    endfunction

    function automatic logic reads_fflags(input slot_t s);
        return s.valid && s.op.csr_read && (s.caddr == `CSR_FFLAGS || s.caddr == `CSR_FCSR);
    endfunction

    function automatic issued_t collect(
        input slot_t            s,
        input read_data_t       d,
        input logic [`XLEN-1:0] c
    );
        issued_t i;
        i.slot   = s;
        i.rdata1 = d.rdata1;
        i.rdata2 = d.rdata2;
        i.crdata = s.op.csr_read ? c : '0;
        return i;
    endfunction

    assign slot0 = gate_fp(pair.slot0, status);
    assign slot1 = gate_fp(pair.slot1, status);

    // operand requests, only for valid slots
    assign rd0.rden1  = slot0.valid & slot0.op.rden1;
    assign rd0.rden2  = slot0.valid & slot0.op.rden2;
    assign rd0.raddr1 = slot0.raddr1;
    assign rd0.raddr2 = slot0.raddr2;
    assign rd1.rden1  = slot1.valid & slot1.op.rden1;
    assign rd1.rden2  = slot1.valid & slot1.op.rden2;
    assign rd1.raddr1 = slot1.raddr1;
    assign rd1.raddr2 = slot1.raddr2;

    assign csr_addr = (slot0.valid && slot0.op.csr_read) ? slot0.caddr : slot1.caddr;

    // ##################################################
    // stall
    // ##################################################

    assign later[0] = exec_fb.fb0;
    assign later[1] = exec_fb.fb1;
    assign later[2] = mem_fb.fb0;
    assign later[3] = mem_fb.fb1;

    always_comb begin
        csr_in_flight = 1'b0;
        fp_in_flight  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            csr_in_flight |= later[i].valid & later[i].op.csr_write;
            fp_in_flight  |= later[i].valid & later[i].op.fp_flags;
        end
    end

    assign load_use = load_use_hit(exec_fb.fb0, slot0) | load_use_hit(exec_fb.fb1, slot0)
                    | load_use_hit(exec_fb.fb0, slot1) | load_use_hit(exec_fb.fb1, slot1);

    assign stall = ((slot0.valid | slot1.valid) & csr_in_flight)
                 | ((reads_fflags(slot0) | reads_fflags(slot1)) & fp_in_flight)
                 | load_use;

    // ##################################################
    // issue register
    // ##################################################

    always_comb begin
        issued_next.issued0 = collect(slot0, fwd0, csr_data);
        issued_next.issued1 = collect(slot1, fwd1, csr_data);
        if (stall || flush) begin
            issued_next.issued0.slot.valid = 1'b0;   // bubbles
            issued_next.issued0.slot.op    = '0;
            issued_next.issued1.slot.valid = 1'b0;
            issued_next.issued1.slot.op    = '0;
        end
    end

    always_ff @(posedge clock) begin
        issued <= issued_next;
        if (!reset) begin
            issued.issued0.slot.valid <= 1'b0;
            issued.issued0.slot.op    <= '0;
            issued.issued1.slot.valid <= 1'b0;
            issued.issued1.slot.op    <= '0;
        end
    end

endmodule

/* issue_top.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module issue_top (
    input  logic                           clock,
    input  logic                           reset,
    input  dual_issue_pkg::slot_pair_t     pair,
    input  dual_issue_pkg::stage_pair_fb_t exec_fb,
    input  dual_issue_pkg::stage_pair_fb_t mem_fb,
    input  dual_issue_pkg::wb_port_t       wb0,
    input  dual_issue_pkg::wb_port_t       wb1,
    input  dual_issue_pkg::csr_write_t     csr_wr,
    input  logic                           flush,
    output logic                           stall,
    output dual_issue_pkg::issued_pair_t   issued
);
    import dual_issue_pkg::*;

    read_req_t              rd0;
    read_req_t              rd1;
    read_data_t             reg0;
    read_data_t             reg1;
    read_data_t             fwd0;
    read_data_t             fwd1;
    fp_status_t             status;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_data;

    issue_stage issue (
        .clock    (clock),
        .reset    (reset),
        .pair     (pair),
        .exec_fb  (exec_fb),
        .mem_fb   (mem_fb),
        .flush    (flush),
        .status   (status),
        .rd0      (rd0),
        .rd1      (rd1),
        .fwd0     (fwd0),
        .fwd1     (fwd1),
        .csr_addr (csr_addr),
        .csr_data (csr_data),
        .stall    (stall),
        .issued   (issued)
    );

    register_file regfile (
        .clock (clock),
        .reset (reset),
        .rd0   (rd0),
        .rd1   (rd1),
        .wb0   (wb0),
        .wb1   (wb1),
        .data0 (reg0),
        .data1 (reg1)
    );

    operand_forward fwd_lane0 (
        .req      (rd0),
        .reg_data (reg0),
        .exec_fb  (exec_fb),
        .mem_fb   (mem_fb),
        .wb0      (wb0),
        .wb1      (wb1),
        .data     (fwd0)
    );

    operand_forward fwd_lane1 (
        .req      (rd1),
        .reg_data (reg1),
        .exec_fb  (exec_fb),
        .mem_fb   (mem_fb),
        .wb0      (wb0),
        .wb1      (wb1),
        .data     (fwd1)
    );

    fp_status_regs fp_status (
        .clock     (clock),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .read_addr (csr_addr),
        .status    (status),
        .read_data (csr_data)
    );

endmodule

/* tb_issue.sv */
`timescale 1ns/1ps
`include "dual_issue_settings.svh"

module tb_issue;
    import dual_issue_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = 4000;   // the directed sequence needs under 200

    logic             clock;
    logic             reset;
    slot_pair_t       pair;
    stage_pair_fb_t   exec_fb;
    stage_pair_fb_t   mem_fb;
    wb_port_t         wb0;
    wb_port_t         wb1;
    csr_write_t       csr_wr;
    logic             flush;
    logic             stall;
    issued_pair_t     issued;

    logic [`XLEN-1:0] model [`REG_COUNT];   // reference register contents
    logic [31:0]      lcg_state;
    logic [1:0]       fs_copy;
    logic [2:0]       frm_copy;
    logic [4:0]       fflags_copy;

    issue_top dut (
        .clock   (clock),
        .reset   (reset),
        .pair    (pair),
        .exec_fb (exec_fb),
        .mem_fb  (mem_fb),
        .wb0     (wb0),
        .wb1     (wb1),
        .csr_wr  (csr_wr),
        .flush   (flush),
        .stall   (stall),
        .issued  (issued)
    );

    always #2 clock = ~clock;

    // ##################################################
    // stimulus helpers
    // ##################################################

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function slot_t make_slot(
        input logic [31:0] pc,
        input logic        rden1,
        input logic [4:0]  raddr1,
        input logic        rden2,
        input logic [4:0]  raddr2
    );
        slot_t s;
        s          = '0;
        s.valid    = 1'b1;
        s.pc       = pc;
        s.op.rden1 = rden1;
        s.op.rden2 = rden2;
        s.op.wren  = 1'b1;
        s.raddr1   = raddr1;
        s.raddr2   = raddr2;
        s.waddr    = 5'd20;
        return s;
    endfunction

    function stage_fb_t producer(input logic load, input logic [4:0] waddr, input logic [31:0] res);
        stage_fb_t f;
        f         = '0;
        f.valid   = 1'b1;
        f.op.wren = 1'b1;
        f.op.load = load;
        f.waddr   = waddr;
        f.result  = res;
        return f;
    endfunction

    // slot as it should leave the issue register under the current fs and frm
    function slot_t expect_fp(input slot_t s);
        slot_t e;
        e = s;
        if (fs_copy == 2'd0) begin
            e.op.fp_op    = 1'b0;
            e.op.fp_flags = 1'b0;
            e.rm          = 3'd0;
        end else if (s.rm == 3'd7) begin
            e.rm = frm_copy;   // dynamic rounding
        end
        return e;
    endfunction

    task automatic clear_inputs();
        pair    = '0;
        exec_fb = '0;
        mem_fb  = '0;
        wb0     = '0;
        wb1     = '0;
        csr_wr  = '0;
        flush   = 1'b0;
    endtask

    // one clock, the model follows the writeback ports
    task automatic tick();
        @(posedge clock);
        if (reset && wb0.wren && wb0.waddr != 5'd0) model[wb0.waddr] = wb0.wdata;
        if (reset && wb1.wren && wb1.waddr != 5'd0) model[wb1.waddr] = wb1.wdata;
        #1;
    endtask

    task automatic write_regs(
        input logic [4:0]  a0,
        input logic [31:0] d0,
        input logic [4:0]  a1,
        input logic [31:0] d1
    );
        wb0 = '{wren: 1'b1, waddr: a0, wdata: d0};
        wb1 = '{wren: 1'b1, waddr: a1, wdata: d1};
        tick();
        wb0 = '0;
        wb1 = '0;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        csr_wr = '{strobe: 1'b1, addr: addr, data: data};
        tick();
        csr_wr = '0;
    endtask

    // ##################################################
    // checks
    // ##################################################

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // drive a pair, check stall, then let it pass the issue register
    task automatic present(input slot_pair_t p, input logic exp_stall);
        pair = p;
        #1;
        check_value("stall", {31'd0, stall}, {31'd0, exp_stall});
        tick();
    endtask

    task automatic check_lane(
        input string       lane,
        input issued_t     got,
        input slot_t       sent,
        input logic [31:0] r1,
        input logic [31:0] r2,
        input logic [31:0] cr
    );
        slot_t e;
        e = expect_fp(sent);
        check_value({lane, ".valid"}, {31'd0, got.slot.valid}, {31'd0, e.valid});
        check_value({lane, ".pc"}, got.slot.pc, e.pc);
        check_value({lane, ".op"}, {24'd0, got.slot.op}, {24'd0, e.op});
        check_value({lane, ".raddr1"}, {27'd0, got.slot.raddr1}, {27'd0, e.raddr1});
        check_value({lane, ".raddr2"}, {27'd0, got.slot.raddr2}, {27'd0, e.raddr2});
        check_value({lane, ".waddr"}, {27'd0, got.slot.waddr}, {27'd0, e.waddr});
        check_value({lane, ".caddr"}, {20'd0, got.slot.caddr}, {20'd0, e.caddr});
        check_value({lane, ".rm"}, {29'd0, got.slot.rm}, {29'd0, e.rm});
        check_value({lane, ".rdata1"}, got.rdata1, r1);
        check_value({lane, ".rdata2"}, got.rdata2, r2);
        check_value({lane, ".crdata"}, got.crdata, cr);
    endtask

    task automatic check_bubbles();
        check_value("issued0.valid", {31'd0, issued.issued0.slot.valid}, 32'd0);
        check_value("issued0.op", {24'd0, issued.issued0.slot.op}, 32'd0);
        check_value("issued1.valid", {31'd0, issued.issued1.slot.valid}, 32'd0);
        check_value("issued1.op", {24'd0, issued.issued1.slot.op}, 32'd0);
    endtask

    // slot0 rs1 and slot1 rs2 both read the forwarded register
    task automatic expect_operand(input slot_pair_t p, input logic [31:0] exp);
        present(p, 1'b0);
        check_value("issued0.rdata1", issued.issued0.rdata1, exp);
        check_value("issued1.rdata2", issued.issued1.rdata2, exp);
    endtask

    // ##################################################
    // directed tests
    // ##################################################

    task automatic test_reset();
        check_value("issued0.valid", {31'd0, issued.issued0.slot.valid}, 32'd0);
        check_value("issued1.valid", {31'd0, issued.issued1.slot.valid}, 32'd0);
        check_value("stall", {31'd0, stall}, 32'd0);
    endtask

    task automatic test_register_reads();
        slot_pair_t p;
        for (int a = 1; a < 17; a += 2) begin
            write_regs(5'(a), next_random(), 5'(a + 1), next_random());
        end
        write_regs(5'd0, next_random(), 5'd17, next_random());   // x0 must stay zero
        write_regs(5'd18, next_random(), 5'd18, next_random());
        p.slot0 = make_slot(32'h100, 1'b1, 5'd1, 1'b1, 5'd2);
        p.slot1 = make_slot(32'h104, 1'b1, 5'd3, 1'b1, 5'd4);
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, model[1], model[2], 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, model[3], model[4], 32'd0);
        p.slot0 = make_slot(32'h108, 1'b1, 5'd0, 1'b1, 5'd18);
        p.slot1 = make_slot(32'h10c, 1'b0, 5'd5, 1'b1, 5'd17);
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, 32'd0, model[18], 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, model[17], 32'd0);
        clear_inputs();
    endtask

    task automatic test_forwarding();
        slot_pair_t  p;
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] m0;
        logic [31:0] m1;
        logic [31:0] w0;
        logic [31:0] w1;
        e0 = next_random();
        e1 = next_random();
        m0 = next_random();
        m1 = next_random();
        w0 = next_random();
        w1 = next_random();
        p.slot0     = make_slot(32'h200, 1'b1, 5'd10, 1'b0, 5'd0);
        p.slot1     = make_slot(32'h204, 1'b1, 5'd3, 1'b1, 5'd10);
        exec_fb.fb0 = producer(1'b0, 5'd10, e0);
        exec_fb.fb1 = producer(1'b0, 5'd10, e1);
        mem_fb.fb0  = producer(1'b0, 5'd10, m0);
        mem_fb.fb1  = producer(1'b0, 5'd10, m1);
        wb0         = '{wren: 1'b1, waddr: 5'd10, wdata: w0};
        wb1         = '{wren: 1'b1, waddr: 5'd10, wdata: w1};
        expect_operand(p, e1);
        exec_fb.fb1 = '0;
        expect_operand(p, e0);
        exec_fb = '0;
        expect_operand(p, m1);
        mem_fb.fb1 = '0;
        expect_operand(p, m0);
        mem_fb = '0;
        expect_operand(p, w1);
        wb1 = '0;
        expect_operand(p, w0);
        wb0 = '0;
        expect_operand(p, model[10]);
        clear_inputs();
    endtask

    task automatic test_load_use();
        slot_pair_t  p;
        logic [31:0] m;
        m = next_random();
        p.slot0     = make_slot(32'h300, 1'b1, 5'd1, 1'b0, 5'd0);
        p.slot1     = make_slot(32'h304, 1'b0, 5'd0, 1'b1, 5'd12);
        exec_fb.fb0 = producer(1'b1, 5'd12, next_random());   // load result not ready
        mem_fb.fb1  = producer(1'b0, 5'd12, m);
        present(p, 1'b1);
        check_bubbles();
        p.slot1.op.rden2 = 1'b0;
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, model[1], 32'd0, 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0, 32'd0);
        p.slot1.op.rden2 = 1'b1;
        p.slot1.raddr2   = 5'd13;
        present(p, 1'b0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, model[13], 32'd0);
        exec_fb.fb1 = producer(1'b1, 5'd1, next_random());
        present(p, 1'b1);   // slot0 now waits on the second load
        check_bubbles();
        exec_fb        = '0;
        p.slot1.raddr2 = 5'd12;
        present(p, 1'b0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, m, 32'd0);
        clear_inputs();
    endtask

    task automatic test_csr_fp();
        slot_pair_t  p;
        logic [31:0] r;
        write_csr(`CSR_FSTATE, 32'd1);
        fs_copy  = 2'd1;
        frm_copy = 3'(next_random() % 32'd5);
        write_csr(`CSR_FRM, {29'd0, frm_copy});
        r           = next_random();
        fflags_copy = r[4:0];
        write_csr(`CSR_FFLAGS, {27'd0, fflags_copy});
        p.slot0          = make_slot(32'h400, 1'b1, 5'd2, 1'b0, 5'd0);
        p.slot0.op.fp_op = 1'b1;
        p.slot0.rm       = 3'd7;
        p.slot1          = make_slot(32'h404, 1'b0, 5'd0, 1'b0, 5'd0);
        p.slot1.op.fp_op = 1'b1;
        p.slot1.rm       = 3'd1;
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, model[2], 32'd0, 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0, 32'd0);
        // csr reads, slot0 owns the read port first
        p.slot0             = make_slot(32'h408, 1'b0, 5'd0, 1'b0, 5'd0);
        p.slot0.op.csr_read = 1'b1;
        p.slot0.caddr       = `CSR_FRM;
        p.slot1             = make_slot(32'h40c, 1'b0, 5'd0, 1'b0, 5'd0);
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, 32'd0, 32'd0, {29'd0, frm_copy});
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0, 32'd0);
        p.slot0.op.csr_read = 1'b0;
        p.slot1.op.csr_read = 1'b1;
        p.slot1.caddr       = `CSR_FCSR;
        present(p, 1'b0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0,
                   {24'd0, frm_copy, fflags_copy});
        exec_fb.fb0             = producer(1'b0, 5'd21, 32'd0);
        exec_fb.fb0.op.fp_flags = 1'b1;
        p.slot1.caddr           = `CSR_FFLAGS;
        present(p, 1'b1);
        check_bubbles();
        exec_fb = '0;
        present(p, 1'b0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0, {27'd0, fflags_copy});
        mem_fb.fb1              = producer(1'b0, 5'd0, 32'd0);
        mem_fb.fb1.op.wren      = 1'b0;
        mem_fb.fb1.op.csr_write = 1'b1;
        present(p, 1'b1);
        check_bubbles();
        clear_inputs();
        write_csr(`CSR_FSTATE, 32'd0);   // fp unit off
        fs_copy                 = 2'd0;
        p.slot0                 = make_slot(32'h410, 1'b0, 5'd0, 1'b0, 5'd0);
        p.slot0.op.fp_op        = 1'b1;
        p.slot0.op.fp_flags     = 1'b1;
        p.slot0.rm              = 3'd7;
        p.slot1                 = make_slot(32'h414, 1'b0, 5'd0, 1'b0, 5'd0);
        p.slot1.op.fp_op        = 1'b1;
        p.slot1.rm              = 3'd2;
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, 32'd0, 32'd0, 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, 32'd0, 32'd0, 32'd0);
        clear_inputs();
    endtask

    task automatic test_flush();
        slot_pair_t p;
        p.slot0 = make_slot(32'h500, 1'b1, 5'd1, 1'b1, 5'd2);
        p.slot1 = make_slot(32'h504, 1'b1, 5'd3, 1'b1, 5'd4);
        flush   = 1'b1;
        present(p, 1'b0);
        check_bubbles();
        mem_fb.fb0              = producer(1'b0, 5'd0, 32'd0);
        mem_fb.fb0.op.csr_write = 1'b1;
        present(p, 1'b1);
        check_bubbles();
        clear_inputs();
        present(p, 1'b0);
        check_lane("issued0", issued.issued0, p.slot0, model[1], model[2], 32'd0);
        check_lane("issued1", issued.issued1, p.slot1, model[3], model[4], 32'd0);
        clear_inputs();
    endtask

    // ##################################################
    // sequence and watchdog
    // ##################################################

    initial begin
        clock       = 1'b0;
        reset       = 1'b0;
        lcg_state   = 32'hfdf8;
        fs_copy     = 2'd0;
        frm_copy    = 3'd0;
        fflags_copy = 5'd0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b1;
        test_reset();
        test_register_reads();
        test_forwarding();
        test_load_use();
        test_csr_fp();
        test_flush();
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $fatal(1);
    end

endmodule

/* dual_issue.f */
+incdir+.
dual_issue_pkg.sv
register_file.sv
operand_forward.sv
fp_status_regs.sv
issue_stage.sv
issue_top.sv
tb_issue.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f dual_issue.f --top-module tb_issue \
    --Mdir obj_dir -o sim_issue
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_issue > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation finished without failure"
exit 0
